// ==== sources.f ====
+incdir+include
src/dmac_pkg.sv
src/dmac_reg_frontend.sv
src/dmac_job_queue.sv
src/dmac_copy_backend.sv
src/dmac_top.sv
verif/tb_dmac.sv

// ==== Makefile ====
# Verilator build and run of the DMA engine testbench

SIM  := obj_dir/Vtb_dmac
SRCS := $(filter-out +incdir+%,$(shell cat sources.f)) include/dmac_settings.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing --top-module tb_dmac -f sources.f -o Vtb_dmac

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'SIMULATION PASSED'

clean:
	rm -rf obj_dir

// ==== verif/tb_dmac.sv ====
/*
  Testbench for the DMA engine. Drives the APB port, serves both memory ports
  from one memory model with random grants and read latency, and checks every
  copy against a reference memory updated in launch order.
*/

`timescale 1ns/1ps
`include "dmac_settings.svh"

module tb_dmac
  import dmac_pkg::*;
();

  localparam int mem_words    = 1024;
  localparam int apb_timeout  = 2000;
  localparam int idle_timeout = 8000;

  logic   clk_i;
  logic   rst_i;
  logic   psel_i;
  logic   penable_i;
  logic   pwrite_i;
  paddr_t paddr_i;
  data_t  pwdata_i;
  data_t  prdata_o;
  logic   pready_o;
  logic   pslverr_o;
  logic   rd_req_o;
  addr_t  rd_addr_o;
  logic   rd_gnt_i    = 1'b0;
  logic   rd_rvalid_i = 1'b0;
  data_t  rd_rdata_i  = '0;
  logic   wr_req_o;
  addr_t  wr_addr_o;
  data_t  wr_wdata_o;
  logic   wr_gnt_i    = 1'b0;
  logic   term_event_o;
  logic   busy_o;

  integer seed       = 32'hb07b_1f92;
  data_t  mem [mem_words];
  data_t  ref_mem [mem_words];
  logic   mem_filled = 1'b0;
  logic   hold_wr    = 1'b0;
  int     due_q[$];
  data_t  data_q[$];
  int     cyc_cnt    = 0;
  int     last_due   = 0;
  int     errors     = 0;
  int     checks     = 0;
  int     term_cnt   = 0;
  int     launched   = 0;
  int     next_id    = 1;

  dmac_top i_dut (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .psel_i       ( psel_i       ),
    .penable_i    ( penable_i    ),
    .pwrite_i     ( pwrite_i     ),
    .paddr_i      ( paddr_i      ),
    .pwdata_i     ( pwdata_i     ),
    .prdata_o     ( prdata_o     ),
    .pready_o     ( pready_o     ),
    .pslverr_o    ( pslverr_o    ),
    .rd_req_o     ( rd_req_o     ),
    .rd_addr_o    ( rd_addr_o    ),
    .rd_gnt_i     ( rd_gnt_i     ),
    .rd_rvalid_i  ( rd_rvalid_i  ),
    .rd_rdata_i   ( rd_rdata_i   ),
    .wr_req_o     ( wr_req_o     ),
    .wr_addr_o    ( wr_addr_o    ),
    .wr_wdata_o   ( wr_wdata_o   ),
    .wr_gnt_i     ( wr_gnt_i     ),
    .term_event_o ( term_event_o ),
    .busy_o       ( busy_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Memory model with random grants and in-order read latency
  // ------------------------------------------------------------

  always @(posedge clk_i) begin : mem_model
    int i;
    int due;
    if (rst_i) begin
      if (!mem_filled) begin
        for (i = 0; i < mem_words; i++) mem[i] = $random(seed);
        mem_filled = 1'b1;
      end
      due_q.delete();
      data_q.delete();
      rd_gnt_i    <= 1'b0;
      wr_gnt_i    <= 1'b0;
      rd_rvalid_i <= 1'b0;
    end else begin
      cyc_cnt = cyc_cnt + 1;
      if (rd_req_o && rd_gnt_i) begin
        due = cyc_cnt + 1 + int'($unsigned($random(seed)) % 4);
        // Keep return order behind the previous read
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        due_q.push_back(due);
        data_q.push_back(mem[rd_addr_o[11:2]]);
      end
      if (wr_req_o && wr_gnt_i) mem[wr_addr_o[11:2]] = wr_wdata_o;
      if (due_q.size() != 0 && due_q[0] <= cyc_cnt) begin
        due = due_q.pop_front();
        rd_rvalid_i <= 1'b1;
        rd_rdata_i  <= data_q.pop_front();
      end else begin
        rd_rvalid_i <= 1'b0;
      end
      rd_gnt_i <= (($random(seed) & 3) != 0);
      wr_gnt_i <= !hold_wr && (($random(seed) & 3) != 0);
    end
  end

  always @(posedge clk_i) begin
    if (!rst_i && term_event_o) term_cnt = term_cnt + 1;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  task automatic check(input string name, input data_t got, input data_t expected);
    checks = checks + 1;
    if (got !== expected) begin
      errors = errors + 1;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
    end
  endtask

  task automatic apb_access(input logic write, input paddr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
    int   waited;
    logic finished;
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    waited   = 0;
    finished = 1'b0;
    rdata    = '0;
    err      = 1'b0;
    while (!finished && waited < apb_timeout) begin
      @(posedge clk_i);
      waited = waited + 1;
      if (pready_o) begin
        finished = 1'b1;
        rdata    = prdata_o;
        err      = pslverr_o;
      end
    end
    if (!finished) begin
      errors = errors + 1;
      $display("APB access to offset 0x%02h did not complete within %0d cycles",
               addr, apb_timeout);
    end
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_write(input paddr_t addr, input data_t wdata);
    data_t rdata;
    logic  err;
    apb_access(1'b1, addr, wdata, rdata, err);
    check("pslverr_o", 32'(err), 32'd0);
  endtask

  task automatic apb_read(input paddr_t addr, output data_t rdata);
    logic err;
    apb_access(1'b0, addr, '0, rdata, err);
    check("pslverr_o", 32'(err), 32'd0);
  endtask

  // Program one job, launch it and copy it in the reference memory
  task automatic launch_job(input int src_w, input int dst_w, input int words);
    data_t id;
    int    i;
    apb_write(`DMAC_REG_SRC, 32'(src_w * 4) + ($unsigned($random(seed)) % 4));
    apb_write(`DMAC_REG_DST, 32'(dst_w * 4) + ($unsigned($random(seed)) % 4));
    apb_write(`DMAC_REG_LEN, 32'(words * 4) + ($unsigned($random(seed)) % 4));
    apb_read(`DMAC_REG_NEXT_ID, id);
    check("next_id", id, 32'(next_id));
    next_id  = next_id + 1;
    launched = launched + 1;
    for (i = 0; i < words; i++) ref_mem[dst_w + i] = ref_mem[src_w + i];
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (busy_o && waited < idle_timeout) begin
      @(posedge clk_i);
      waited = waited + 1;
    end
    if (busy_o) begin
      errors = errors + 1;
      $display("DMA engine still busy after %0d cycles", idle_timeout);
    end
  endtask

  task automatic compare_memory();
    int i;
    for (i = 0; i < mem_words; i++) check($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin : main
    data_t rdata;
    data_t value;
    logic  err;
    int    i;
    int    stalled;
    int    waited;
    int    src_w;
    int    dst_w;
    int    words;
    rst_i     <= 1'b1;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= '0;
    pwdata_i  <= '0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    for (i = 0; i < mem_words; i++) ref_mem[i] = mem[i];

    // Reset state and register readback
    apb_read(`DMAC_REG_STATUS, rdata);
    check("status", rdata, 32'd0);
    apb_read(`DMAC_REG_DONE_ID, rdata);
    check("done_id", rdata, 32'd0);
    value = $random(seed);
    apb_write(`DMAC_REG_SRC, value);
    apb_read(`DMAC_REG_SRC, rdata);
    check("src", rdata, value);
    value = $random(seed);
    apb_write(`DMAC_REG_DST, value);
    apb_read(`DMAC_REG_DST, rdata);
    check("dst", rdata, value);
    value = $random(seed);
    apb_write(`DMAC_REG_LEN, value);
    apb_read(`DMAC_REG_LEN, rdata);
    check("len", rdata, value & 32'h0000_ffff);

    // Sources in the lower half, destinations in the upper half
    for (i = 0; i < 20; i++) begin
      launch_job(int'($unsigned($random(seed)) % 496),
                 512 + int'($unsigned($random(seed)) % 496),
                 int'($unsigned($random(seed)) % 17));
    end
    wait_idle();
    compare_memory();

    // Writes held so backend and queue fill up before one more launch
    hold_wr <= 1'b1;
    for (i = 0; i < `DMAC_QUEUE_DEPTH + 1; i++) begin
      launch_job(int'($unsigned($random(seed)) % 496),
                 512 + int'($unsigned($random(seed)) % 496),
                 1 + int'($unsigned($random(seed)) % 16));
    end
    apb_read(`DMAC_REG_STATUS, rdata);
    check("status", rdata, 32'd1);
    src_w   = int'($unsigned($random(seed)) % 496);
    dst_w   = 512 + int'($unsigned($random(seed)) % 496);
    words   = 1 + int'($unsigned($random(seed)) % 16);
    stalled = 0;
    fork
      launch_job(src_w, dst_w, words);
      begin
        waited = 0;
        @(posedge clk_i);
        while (!(psel_i && penable_i && !pwrite_i && paddr_i == `DMAC_REG_NEXT_ID)
               && waited < apb_timeout) begin
          @(posedge clk_i);
          waited = waited + 1;
        end
        if (waited >= apb_timeout) begin
          errors = errors + 1;
          $display("Launch read with a full queue never reached its access phase");
        end
        repeat (16) begin
          @(posedge clk_i);
          if (!pready_o) stalled = stalled + 1;
        end
        hold_wr <= 1'b0;
      end
    join
    check("stalled cycles", 32'(stalled), 32'd16);
    wait_idle();
    compare_memory();

    // Unmapped offsets and read-only registers
    apb_access(1'b0, 8'h18, '0, rdata, err);
    check("pslverr_o", 32'(err), 32'd1);
    check("prdata_o", rdata, 32'd0);
    apb_access(1'b1, 8'h40, 32'hdead_beef, rdata, err);
    check("pslverr_o", 32'(err), 32'd1);
    apb_write(`DMAC_REG_STATUS, 32'hffff_ffff);
    apb_write(`DMAC_REG_NEXT_ID, 32'hffff_ffff);
    apb_write(`DMAC_REG_DONE_ID, 32'hffff_ffff);

    // Completion count
    apb_read(`DMAC_REG_DONE_ID, rdata);
    check("done_id", rdata, 32'(launched));
    check("term_event_o count", 32'(term_cnt), 32'(launched));
    check("busy_o", 32'(busy_o), 32'd0);
    apb_read(`DMAC_REG_STATUS, rdata);
    check("status", rdata, 32'd0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== src/dmac_top.sv ====
/*
  Top level of the single channel DMA engine. APB control port in front,
  job queue in the middle, copy backend on separate memory read and write ports.
*/

`timescale 1ns/1ps
`include "dmac_settings.svh"

module dmac_top
  import dmac_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  // APB control port
  input  logic   psel_i,
  input  logic   penable_i,
  input  logic   pwrite_i,
  input  paddr_t paddr_i,
  input  data_t  pwdata_i,
  output data_t  prdata_o,
  output logic   pready_o,
  output logic   pslverr_o,
  // Memory read port
  output logic   rd_req_o,
  output addr_t  rd_addr_o,
  input  logic   rd_gnt_i,
  input  logic   rd_rvalid_i,
  input  data_t  rd_rdata_i,
  // Memory write port
  output logic   wr_req_o,
  output addr_t  wr_addr_o,
  output data_t  wr_wdata_o,
  input  logic   wr_gnt_i,
  // Events
  output logic   term_event_o,
  output logic   busy_o
);

  logic  q_push;
  logic  q_full;
  addr_t q_src;
  addr_t q_dst;
  len_t  q_len;
  logic  q_not_empty;
  logic  job_valid;
  logic  job_ready;
  addr_t job_src;
  addr_t job_dst;
  len_t  job_len;
  logic  job_done;
  logic  be_active;
  logic  busy;

  // Busy while a job waits or is being copied
  assign busy         = q_not_empty | be_active;
  assign busy_o       = busy;
  assign term_event_o = job_done;

  // ------------------------------------------------------------
  // Frontend
  // ------------------------------------------------------------

  dmac_reg_frontend i_reg_frontend (
    .clk_i      ( clk_i     ),
    .rst_i      ( rst_i     ),
    .psel_i     ( psel_i    ),
    .penable_i  ( penable_i ),
    .pwrite_i   ( pwrite_i  ),
    .paddr_i    ( paddr_i   ),
    .pwdata_i   ( pwdata_i  ),
    .prdata_o   ( prdata_o  ),
    .pready_o   ( pready_o  ),
    .pslverr_o  ( pslverr_o ),
    .q_push_o   ( q_push    ),
    .q_src_o    ( q_src     ),
    .q_dst_o    ( q_dst     ),
    .q_len_o    ( q_len     ),
    .q_full_i   ( q_full    ),
    .job_done_i ( job_done  ),
    .busy_i     ( busy      )
  );

  dmac_job_queue #(
    .depth ( `DMAC_QUEUE_DEPTH )
  ) i_job_queue (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .push_i      ( q_push      ),
    .src_i       ( q_src       ),
    .dst_i       ( q_dst       ),
    .len_i       ( q_len       ),
    .full_o      ( q_full      ),
    .valid_o     ( job_valid   ),
    .ready_i     ( job_ready   ),
    .src_o       ( job_src     ),
    .dst_o       ( job_dst     ),
    .len_o       ( job_len     ),
    .not_empty_o ( q_not_empty )
  );

  // ------------------------------------------------------------
  // Backend
  // ------------------------------------------------------------

  dmac_copy_backend #(
    .buf_depth ( `DMAC_BUF_DEPTH )
  ) i_copy_backend (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .job_valid_i ( job_valid   ),
    .job_ready_o ( job_ready   ),
    .job_src_i   ( job_src     ),
    .job_dst_i   ( job_dst     ),
    .job_len_i   ( job_len     ),
    .job_done_o  ( job_done    ),
    .active_o    ( be_active   ),
    .rd_req_o    ( rd_req_o    ),
    .rd_addr_o   ( rd_addr_o   ),
    .rd_gnt_i    ( rd_gnt_i    ),
    .rd_rvalid_i ( rd_rvalid_i ),
    .rd_rdata_i  ( rd_rdata_i  ),
    .wr_req_o    ( wr_req_o    ),
    .wr_addr_o   ( wr_addr_o   ),
    .wr_wdata_o  ( wr_wdata_o  ),
    .wr_gnt_i    ( wr_gnt_i    )
  );

endmodule

// ==== src/dmac_copy_backend.sv ====
/*
  Word copy engine. Takes one job at a time from the queue, reads the source
  region through the read port into a small data buffer and drains that buffer
  to the destination through the write port. Pulses job_done_o per job.
*/

`timescale 1ns/1ps
`include "dmac_settings.svh"

module dmac_copy_backend
  import dmac_pkg::*;
#(
  parameter int unsigned buf_depth = `DMAC_BUF_DEPTH
) (
  input  logic  clk_i,
  input  logic  rst_i,
  // Job input
  input  logic  job_valid_i,
  output logic  job_ready_o,
  input  addr_t job_src_i,
  input  addr_t job_dst_i,
  input  len_t  job_len_i,
  output logic  job_done_o,
  output logic  active_o,
  // Memory read port
  output logic  rd_req_o,
  output addr_t rd_addr_o,
  input  logic  rd_gnt_i,
  input  logic  rd_rvalid_i,
  input  data_t rd_rdata_i,
  // Memory write port
  output logic  wr_req_o,
  output addr_t wr_addr_o,
  output data_t wr_wdata_o,
  input  logic  wr_gnt_i
);

  localparam int unsigned ptr_w = $clog2(buf_depth);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [ptr_w:0]   cnt_t;

  localparam cnt_t  buf_limit = cnt_t'(buf_depth);
  localparam addr_t word_step = addr_t'(4);

  copy_state_e state_q;
  logic        done_q;
  addr_t       rd_addr_q;
  addr_t       wr_addr_q;
  words_t      rd_left_q;
  words_t      wr_left_q;
  words_t      job_words;
  cnt_t        outstanding_q;
  cnt_t        buf_cnt_q;
  cnt_t        in_flight;
  ptr_t        buf_wr_ptr_q;
  ptr_t        buf_rd_ptr_q;
  data_t       buf_mem [buf_depth];
  logic        job_take;
  logic        rd_fire;
  logic        wr_fire;
  logic        wr_last;

  assign job_ready_o = (state_q == COPY_IDLE);
  assign job_take    = job_valid_i & job_ready_o;
  // Low two bits of the byte count are dropped
  assign job_words   = job_len_i[`DMAC_LEN_W-1:2];
  assign active_o    = (state_q == COPY_RUN);
  assign job_done_o  = done_q;

  // Reads stop once every buffer slot is claimed by data or an open read
  assign in_flight = outstanding_q + buf_cnt_q;
  assign rd_req_o  = active_o && (rd_left_q != '0) && (in_flight < buf_limit);
  assign rd_fire   = rd_req_o & rd_gnt_i;
  assign rd_addr_o = rd_addr_q;

  assign wr_req_o   = active_o && (buf_cnt_q != '0);
  assign wr_fire    = wr_req_o & wr_gnt_i;
  assign wr_last    = wr_fire && (wr_left_q == words_t'(1));
  assign wr_addr_o  = wr_addr_q;
  assign wr_wdata_o = buf_mem[buf_rd_ptr_q];

  // ------------------------------------------------------------
  // Job FSM and remaining word counts
  // ------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= COPY_IDLE;
      done_q    <= 1'b0;
      rd_left_q <= '0;
      wr_left_q <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        COPY_IDLE: begin
          if (job_take) begin
            rd_left_q <= job_words;
            wr_left_q <= job_words;
            // Empty job finishes right away
            if (job_words == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= COPY_RUN;
            end
          end
        end
        COPY_RUN: begin
          if (rd_fire) rd_left_q <= rd_left_q - words_t'(1);
          if (wr_fire) wr_left_q <= wr_left_q - words_t'(1);
          if (wr_last) begin
            done_q  <= 1'b1;
            state_q <= COPY_IDLE;
          end
        end
        default: state_q <= COPY_IDLE;
      endcase
    end
  end

  // Word aligned address counters
  always_ff @(posedge clk_i) begin
    if (job_take) begin
      rd_addr_q <= {job_src_i[`DMAC_ADDR_W-1:2], 2'b00};
      wr_addr_q <= {job_dst_i[`DMAC_ADDR_W-1:2], 2'b00};
    end else begin
      if (rd_fire) rd_addr_q <= rd_addr_q + word_step;
      if (wr_fire) wr_addr_q <= wr_addr_q + word_step;
    end
  end

  // ------------------------------------------------------------
  // Outstanding reads and read data buffer
  // ------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= '0;
      buf_cnt_q     <= '0;
      buf_wr_ptr_q  <= '0;
      buf_rd_ptr_q  <= '0;
    end else begin
      if (rd_fire && !rd_rvalid_i) begin
        outstanding_q <= outstanding_q + cnt_t'(1);
      end else if (!rd_fire && rd_rvalid_i) begin
        outstanding_q <= outstanding_q - cnt_t'(1);
      end
      if (rd_rvalid_i && !wr_fire) begin
        buf_cnt_q <= buf_cnt_q + cnt_t'(1);
      end else if (!rd_rvalid_i && wr_fire) begin
        buf_cnt_q <= buf_cnt_q - cnt_t'(1);
      end
      if (rd_rvalid_i) buf_wr_ptr_q <= buf_wr_ptr_q + ptr_t'(1);
      if (wr_fire) buf_rd_ptr_q <= buf_rd_ptr_q + ptr_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_rvalid_i) begin
      buf_mem[buf_wr_ptr_q] <= rd_rdata_i;
    end
  end

endmodule

// ==== src/dmac_job_queue.sv ====
/*
  In-order FIFO of launched jobs between register frontend and copy backend.
  A pushed job shows up on valid_o in the following cycle.
*/

`timescale 1ns/1ps
`include "dmac_settings.svh"

module dmac_job_queue
  import dmac_pkg::*;
#(
  parameter int unsigned depth = `DMAC_QUEUE_DEPTH
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  push_i,
  input  addr_t src_i,
  input  addr_t dst_i,
  input  len_t  len_i,
  output logic  full_o,
  output logic  valid_o,
  input  logic  ready_i,
  output addr_t src_o,
  output addr_t dst_o,
  output len_t  len_o,
  output logic  not_empty_o
);

  localparam int unsigned ptr_w = $clog2(depth);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [ptr_w:0]   cnt_t;

  localparam cnt_t full_cnt = cnt_t'(depth);

  addr_t src_mem [depth];
  addr_t dst_mem [depth];
  len_t  len_mem [depth];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  count_q;
  logic  do_push;
  logic  do_pop;

  assign full_o      = (count_q == full_cnt);
  assign valid_o     = (count_q != '0);
  assign not_empty_o = valid_o;
  assign do_push     = push_i & ~full_o;
  assign do_pop      = valid_o & ready_i;

  assign src_o = src_mem[rd_ptr_q];
  assign dst_o = dst_mem[rd_ptr_q];
  assign len_o = len_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      src_mem[wr_ptr_q] <= src_i;
      dst_mem[wr_ptr_q] <= dst_i;
      len_mem[wr_ptr_q] <= len_i;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      if (do_pop) rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      if (do_push && !do_pop) begin
        count_q <= count_q + cnt_t'(1);
      end else if (!do_push && do_pop) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

endmodule

// ==== src/dmac_reg_frontend.sv ====
/*
  APB register file of the DMA engine. Software writes SRC, DST and LEN,
  then reads NEXT_ID to launch the job and obtain its ID. DONE_ID counts
  finished jobs, STATUS shows the busy flag.
*/

`timescale 1ns/1ps
`include "dmac_settings.svh"

module dmac_reg_frontend
  import dmac_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  // APB slave
  input  logic    psel_i,
  input  logic    penable_i,
  input  logic    pwrite_i,
  input  paddr_t  paddr_i,
  input  data_t   pwdata_i,
  output data_t   prdata_o,
  output logic    pready_o,
  output logic    pslverr_o,
  // Job queue push side
  output logic    q_push_o,
  output addr_t   q_src_o,
  output addr_t   q_dst_o,
  output len_t    q_len_o,
  input  logic    q_full_i,
  // Status sources
  input  logic    job_done_i,
  input  logic    busy_i
);

  logic    apb_access;
  logic    apb_wr;
  logic    apb_rd;
  logic    sel_src;
  logic    sel_dst;
  logic    sel_len;
  logic    sel_status;
  logic    sel_next_id;
  logic    sel_done_id;
  logic    mapped;
  logic    launch_stall;
  addr_t   src_q;
  addr_t   dst_q;
  len_t    len_q;
  job_id_t next_id_q;
  job_id_t done_cnt_q;
  job_id_t launch_id;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------

  assign apb_access = psel_i & penable_i;
  assign apb_wr     = apb_access & pwrite_i;
  assign apb_rd     = apb_access & ~pwrite_i;

  assign sel_src     = (paddr_i == `DMAC_REG_SRC);
  assign sel_dst     = (paddr_i == `DMAC_REG_DST);
  assign sel_len     = (paddr_i == `DMAC_REG_LEN);
  assign sel_status  = (paddr_i == `DMAC_REG_STATUS);
  assign sel_next_id = (paddr_i == `DMAC_REG_NEXT_ID);
  assign sel_done_id = (paddr_i == `DMAC_REG_DONE_ID);

  assign mapped = sel_src | sel_dst | sel_len | sel_status | sel_next_id | sel_done_id;

  // A launch holds the access phase while the queue has no room
  assign launch_stall = apb_rd & sel_next_id & q_full_i;
  assign pready_o     = ~launch_stall;
  assign pslverr_o    = apb_access & ~mapped;

  assign launch_id = next_id_q + job_id_t'(1);
  assign q_push_o  = apb_rd & sel_next_id & ~q_full_i;
  assign q_src_o   = src_q;
  assign q_dst_o   = dst_q;
  assign q_len_o   = len_q;

  // ------------------------------------------------------------
  // Job registers
  // ------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (apb_wr) begin
      if (sel_src) src_q <= addr_t'(pwdata_i);
      if (sel_dst) dst_q <= addr_t'(pwdata_i);
      if (sel_len) len_q <= pwdata_i[`DMAC_LEN_W-1:0];
    end
  end

  // ID counters, first launched job gets ID 1
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      next_id_q  <= '0;
      done_cnt_q <= '0;
    end else begin
      if (q_push_o) next_id_q <= launch_id;
      if (job_done_i) done_cnt_q <= done_cnt_q + job_id_t'(1);
    end
  end

  // Read data, valid in the access cycle
  always_comb begin
    prdata_o = '0;
    if (apb_rd) begin
      case (paddr_i)
        `DMAC_REG_SRC:     prdata_o = data_t'(src_q);
        `DMAC_REG_DST:     prdata_o = data_t'(dst_q);
        `DMAC_REG_LEN:     prdata_o = data_t'(len_q);
        `DMAC_REG_STATUS:  prdata_o = data_t'(busy_i);
        `DMAC_REG_NEXT_ID: prdata_o = data_t'(launch_id);
        `DMAC_REG_DONE_ID: prdata_o = data_t'(done_cnt_q);
        default:           prdata_o = '0;
      endcase
    end
  end

endmodule

// ==== src/dmac_pkg.sv ====
/*
  Shared vector types and the backend state encoding of the DMA engine.
  Modules pull these in with a wildcard import in their header.
*/

`include "dmac_settings.svh"

package dmac_pkg;

  // Memory side
  typedef logic [`DMAC_ADDR_W-1:0]  addr_t;
  typedef logic [`DMAC_DATA_W-1:0]  data_t;

  // Transfer description
  typedef logic [`DMAC_LEN_W-1:0]   len_t;
  typedef logic [`DMAC_LEN_W-3:0]   words_t;
  typedef logic [`DMAC_ID_W-1:0]    job_id_t;

  // Control port
  typedef logic [`DMAC_PADDR_W-1:0] paddr_t;

  // Copy engine states
  typedef enum logic {
    COPY_IDLE = 1'b0,
    COPY_RUN  = 1'b1
  } copy_state_e;

endpackage

// ==== include/dmac_settings.svh ====
/*
  Widths, depths and APB register offsets of the DMA engine.
  Included by the package and by every RTL module that needs a constant.
*/

`ifndef DMAC_SETTINGS_SVH
`define DMAC_SETTINGS_SVH

// Datapath widths
`define DMAC_ADDR_W       32
`define DMAC_DATA_W       32
`define DMAC_LEN_W        16
`define DMAC_ID_W         16
`define DMAC_PADDR_W      8

// Storage depths, powers of two
`define DMAC_QUEUE_DEPTH  4
`define DMAC_BUF_DEPTH    4

// APB register map
`define DMAC_REG_SRC      8'h00
`define DMAC_REG_DST      8'h04
`define DMAC_REG_LEN      8'h08
`define DMAC_REG_STATUS   8'h0C
`define DMAC_REG_NEXT_ID  8'h10
`define DMAC_REG_DONE_ID  8'h14

`endif
